// File: rtl/gfxPkg.sv
package gfxPkg;

	////////////////////////////////////////
	// field widths and reset values
	////////////////////////////////////////

	localparam int ROW_BITS      = 9;   // 512 rows
	localparam int COL_WORD_BITS = 9;   // 1024 pixels, two per word

	typedef logic signed [15:0] coord_t;   // pixel coordinate
	typedef logic [7:0]         colour_t;  // palette index, one pixel
	typedef logic [15:0]        cpuData_t;
	typedef logic [15:0]        cpuAddr_t;
	typedef logic [ROW_BITS+COL_WORD_BITS-1:0] fbAddr_t;  // {row, word column}
	typedef logic [15:0]        fbData_t;

	localparam logic [7:0] REG_PAGE     = 8'h00;     // upper address byte of the register page
	localparam coord_t     X2_RESET     = 16'sd1024;
	localparam coord_t     Y2_RESET     = 16'sd512;
	localparam colour_t    COLOUR_RESET = 8'd4;

	// word offsets, byte offset is twice this
	typedef enum logic [6:0] {
		COMMAND = 7'd0,
		X1      = 7'd1,
		Y1      = 7'd2,
		X2      = 7'd3,
		Y2      = 7'd4,
		COLOUR  = 7'd7
	} regOffset_e;

	typedef enum logic [15:0] {
		CMD_HLINE    = 16'h0001,
		CMD_VLINE    = 16'h0002,
		CMD_ALINE    = 16'h0003,
		CMD_PUTPIXEL = 16'h000A
	} command_e;

	////////////////////////////////////////
	// bundles between blocks
	////////////////////////////////////////

	typedef struct packed {
		logic     csN;
		logic     asN;
		logic     udsN;
		logic     ldsN;
		logic     rw;    // 1 for read
		cpuAddr_t addr;
		cpuData_t data;
	} cpuBus_s;

	typedef struct packed {
		coord_t  x1;
		coord_t  y1;
		coord_t  x2;
		coord_t  y2;
		colour_t colour;
	} drawRegs_s;

	typedef struct packed {
		logic   valid;
		coord_t x;
		coord_t y;
		logic   pair;  // x and x+1 in one word
	} pixelReq_s;

	typedef struct packed {
		fbAddr_t addr;
		fbData_t data;
		logic    udsN;
		logic    ldsN;
		logic    rwN;
	} fbBus_s;

endpackage

// File: rtl/gfxRegisterFile.sv
`timescale 1ns/1ps

module gfxRegisterFile (
	input  logic              Clk,
	input  logic              rstN,
	input  gfxPkg::cpuBus_s   cpu,
	output gfxPkg::cpuData_t  cpuReadData,
	output gfxPkg::drawRegs_s regs,
	output logic              spanStart,
	output logic              lineStart,
	output gfxPkg::command_e  command,
	input  logic              spanDone,
	input  logic              lineDone
);

	gfxPkg::regOffset_e offset;
	gfxPkg::cpuData_t   cmdReg;
	logic pageHit;
	logic writeCycle;
	logic readCycle;
	logic pending;     // command written, not yet dispatched
	logic idle;
	logic isSpanCmd;
	logic isLineCmd;
	logic dispatch;

	// merge the enabled byte lanes into the old value
	function automatic gfxPkg::cpuData_t laneWrite(gfxPkg::cpuData_t cur, gfxPkg::cpuBus_s bus);
		gfxPkg::cpuData_t nxt;
		nxt = cur;
		if (!bus.udsN)
			nxt[15:8] = bus.data[15:8];  // even byte
		if (!bus.ldsN)
			nxt[7:0] = bus.data[7:0];
		return nxt;
	endfunction

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	assign offset     = gfxPkg::regOffset_e'(cpu.addr[7:1]);
	assign pageHit    = !cpu.csN && !cpu.asN && (cpu.addr[15:8] == gfxPkg::REG_PAGE);
	assign writeCycle = pageHit && !cpu.rw;
	assign readCycle  = pageHit && cpu.rw;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regs.x1     <= '0;
			regs.y1     <= '0;
			regs.x2     <= gfxPkg::X2_RESET;
			regs.y2     <= gfxPkg::Y2_RESET;
			regs.colour <= gfxPkg::COLOUR_RESET;
			cmdReg      <= '0;
		end else if (writeCycle) begin
			case (offset)
				gfxPkg::COMMAND: cmdReg  <= laneWrite(cmdReg, cpu);
				gfxPkg::X1:      regs.x1 <= laneWrite(regs.x1, cpu);
				gfxPkg::Y1:      regs.y1 <= laneWrite(regs.y1, cpu);
				gfxPkg::X2:      regs.x2 <= laneWrite(regs.x2, cpu);
				gfxPkg::Y2:      regs.y2 <= laneWrite(regs.y2, cpu);
				gfxPkg::COLOUR: begin
					if (!cpu.ldsN)
						regs.colour <= cpu.data[7:0];  // one pixel lives in the low lane
				end
				default: ;
			endcase
		end
	end

	// status word, Idle in bit 0, zero when not read
	always_comb begin
		cpuReadData = '0;
		if (readCycle && offset == gfxPkg::COMMAND)
			cpuReadData[0] = idle;
	end

	////////////////////////////////////////
	// dispatch
	////////////////////////////////////////

	assign command   = gfxPkg::command_e'(cmdReg);
	assign isSpanCmd = command inside {gfxPkg::CMD_PUTPIXEL, gfxPkg::CMD_HLINE, gfxPkg::CMD_VLINE};
	assign isLineCmd = command == gfxPkg::CMD_ALINE;
	assign dispatch  = pending && cpu.asN && idle;  // wait for the bus cycle to end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pending   <= 1'b0;
			idle      <= 1'b1;
			spanStart <= 1'b0;
			lineStart <= 1'b0;
		end else begin
			spanStart <= dispatch && isSpanCmd;  // one cycle pulse
			lineStart <= dispatch && isLineCmd;
			if (writeCycle && offset == gfxPkg::COMMAND)
				pending <= 1'b1;
			else if (dispatch)
				pending <= 1'b0;  // unknown codes just drop here
			if (dispatch && (isSpanCmd || isLineCmd))
				idle <= 1'b0;
			else if (spanDone || lineDone)
				idle <= 1'b1;
		end
	end

endmodule

// File: rtl/gfxSpanEngine.sv
`timescale 1ns/1ps

module gfxSpanEngine (
	input  logic              Clk,
	input  logic              rstN,
	input  gfxPkg::drawRegs_s regs,
	input  logic              spanStart,
	input  gfxPkg::command_e  command,
	output gfxPkg::pixelReq_s pixelReq,
	output logic              spanDone
);

	typedef enum logic [1:0] {
		SPAN_IDLE,
		SPAN_PIXEL,   // single putpixel request
		SPAN_SETUP,   // order the endpoints
		SPAN_WALK
	} spanState_e;

	spanState_e     state;
	logic           vertical;  // walking y instead of x
	gfxPkg::coord_t cur;
	gfxPkg::coord_t last;
	gfxPkg::coord_t fixed;     // the coordinate that does not move
	logic           pairHere;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= SPAN_IDLE;
		end else begin
			case (state)
				SPAN_IDLE: begin
					if (spanStart)
						state <= (command == gfxPkg::CMD_PUTPIXEL) ? SPAN_PIXEL : SPAN_SETUP;
				end
				SPAN_PIXEL: state <= SPAN_IDLE;
				SPAN_SETUP: state <= SPAN_WALK;
				SPAN_WALK: begin
					if (cur > last)
						state <= SPAN_IDLE;  // span exhausted
				end
				default: state <= SPAN_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// span datapath
	////////////////////////////////////////

	// two pixels share a word only from an even x with room left
	assign pairHere = !vertical && !cur[0] && (cur < last);

	always_ff @(posedge Clk) begin
		if (state == SPAN_IDLE && spanStart) begin
			vertical <= command == gfxPkg::CMD_VLINE;
			cur      <= regs.x1;  // putpixel operands
			fixed    <= regs.y1;
		end else if (state == SPAN_SETUP) begin
			if (vertical) begin
				cur   <= (regs.y1 > regs.y2) ? regs.y2 : regs.y1;
				last  <= (regs.y1 > regs.y2) ? regs.y1 : regs.y2;
				fixed <= regs.x1;  // column stays at X1
			end else begin
				cur   <= (regs.x1 > regs.x2) ? regs.x2 : regs.x1;
				last  <= (regs.x1 > regs.x2) ? regs.x1 : regs.x2;
				fixed <= regs.y1;
			end
		end else if (state == SPAN_WALK) begin
			cur <= pairHere ? cur + 16'sd2 : cur + 16'sd1;
		end
	end

	always_comb begin
		pixelReq = '0;
		spanDone = 1'b0;
		case (state)
			SPAN_PIXEL: begin
				pixelReq.valid = 1'b1;
				pixelReq.x     = cur;
				pixelReq.y     = fixed;
				spanDone       = 1'b1;  // done with the only request
			end
			SPAN_WALK: begin
				if (cur <= last) begin
					pixelReq.valid = 1'b1;
					pixelReq.x     = vertical ? fixed : cur;
					pixelReq.y     = vertical ? cur : fixed;
					pixelReq.pair  = pairHere;
				end else begin
					spanDone = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/gfxLineEngine.sv
`timescale 1ns/1ps

module gfxLineEngine (
	input  logic              Clk,
	input  logic              rstN,
	input  gfxPkg::drawRegs_s regs,
	input  logic              lineStart,
	output gfxPkg::pixelReq_s pixelReq,
	output logic              lineDone
);

	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_INIT,   // deltas, signs, axis swap
		LINE_PLOT    // one pixel per cycle
	} lineState_e;

	lineState_e state;

	// setup terms from the registers
	logic signed [17:0] diffX;
	logic signed [17:0] diffY;
	logic signed [17:0] absX;
	logic signed [17:0] absY;
	logic signed [17:0] majorNow;
	logic signed [17:0] minorNow;
	logic               steepNow;
	logic               zeroLen;

	// walk state
	logic signed [17:0] majorLen;
	logic signed [17:0] minorLen;
	logic signed [17:0] count;
	logic signed [19:0] err;
	logic               steep;
	logic               negX;
	logic               negY;
	gfxPkg::coord_t     x;
	gfxPkg::coord_t     y;
	gfxPkg::coord_t     stepX;
	gfxPkg::coord_t     stepY;
	logic               minorStep;
	logic               lastPixel;

	////////////////////////////////////////
	// setup
	////////////////////////////////////////

	assign diffX    = regs.x2 - regs.x1;
	assign diffY    = regs.y2 - regs.y1;
	assign absX     = (diffX < 0) ? -diffX : diffX;
	assign absY     = (diffY < 0) ? -diffY : diffY;
	assign steepNow = absY > absX;  // steeper than 45 degrees
	assign majorNow = steepNow ? absY : absX;
	assign minorNow = steepNow ? absX : absY;
	assign zeroLen  = (diffX == 0) && (diffY == 0);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= LINE_IDLE;
		end else begin
			case (state)
				LINE_IDLE: if (lineStart) state <= LINE_INIT;
				LINE_INIT: state <= zeroLen ? LINE_IDLE : LINE_PLOT;
				LINE_PLOT: if (lastPixel) state <= LINE_IDLE;
				default:   state <= LINE_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// error term stepping
	////////////////////////////////////////

	assign minorStep = err >= 0;
	assign stepX     = negX ? x - 16'sd1 : x + 16'sd1;
	assign stepY     = negY ? y - 16'sd1 : y + 16'sd1;
	assign lastPixel = count == majorLen;  // major+1 pixels in total

	always_ff @(posedge Clk) begin
		if (state == LINE_INIT) begin
			x        <= regs.x1;
			y        <= regs.y1;
			steep    <= steepNow;
			negX     <= diffX < 0;
			negY     <= diffY < 0;
			majorLen <= majorNow;
			minorLen <= minorNow;
			err      <= (minorNow <<< 1) - majorNow;  // 2*minor - major
			count    <= '0;
		end else if (state == LINE_PLOT) begin
			if (!steep || minorStep)
				x <= stepX;   // x is major when shallow
			if (steep || minorStep)
				y <= stepY;
			if (minorStep)
				err <= err - (majorLen <<< 1) + (minorLen <<< 1);
			else
				err <= err + (minorLen <<< 1);
			count <= count + 18'sd1;
		end
	end

	always_comb begin
		pixelReq = '0;  // idle engine drives zeros into the merge
		if (state == LINE_PLOT) begin
			pixelReq.valid = 1'b1;
			pixelReq.x     = x;
			pixelReq.y     = y;
		end
		lineDone = (state == LINE_INIT && zeroLen) || (state == LINE_PLOT && lastPixel);
	end

endmodule

// File: rtl/gfxFrameBufferPort.sv
`timescale 1ns/1ps

module gfxFrameBufferPort (
	input  logic              Clk,
	input  logic              rstN,
	input  gfxPkg::pixelReq_s spanReq,
	input  gfxPkg::pixelReq_s lineReq,
	input  gfxPkg::colour_t   colour,
	output gfxPkg::fbBus_s    fb
);

	gfxPkg::pixelReq_s merged;
	gfxPkg::fbAddr_t   wordAddr;
	logic              evenX;

	// only one engine runs at a time so the idle one drives zeros
	assign merged = spanReq | lineReq;
	assign evenX  = !merged.x[0];

	// row from y, word column from x without the byte bit
	assign wordAddr = {merged.y[gfxPkg::ROW_BITS-1:0], merged.x[gfxPkg::COL_WORD_BITS:1]};

	////////////////////////////////////////
	// registered sram pins
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		fb.addr <= wordAddr;
		fb.data <= {colour, colour};  // same pixel in both lanes
		if (!rstN) begin
			fb.udsN <= 1'b1;
			fb.ldsN <= 1'b1;
			fb.rwN  <= 1'b1;
		end else if (merged.valid) begin
			fb.udsN <= !(evenX || merged.pair);   // even pixel in the upper byte
			fb.ldsN <= !(!evenX || merged.pair);  // odd pixel in the lower byte
			fb.rwN  <= 1'b0;
		end else begin
			fb.udsN <= 1'b1;
			fb.ldsN <= 1'b1;
			fb.rwN  <= 1'b1;  // no cycle
		end
	end

endmodule

// File: rtl/gfxController.sv
`timescale 1ns/1ps

module gfxController (
	input  logic             Clk,
	input  logic             rstN,
	input  gfxPkg::cpuBus_s  cpu,
	output gfxPkg::cpuData_t cpuReadData,
	output gfxPkg::fbBus_s   fb
);

	gfxPkg::drawRegs_s regs;
	gfxPkg::command_e  command;
	gfxPkg::pixelReq_s spanReq;
	gfxPkg::pixelReq_s lineReq;
	logic spanStart;
	logic lineStart;
	logic spanDone;
	logic lineDone;

	////////////////////////////////////////
	// cpu side
	////////////////////////////////////////

	gfxRegisterFile gfxRegisterFile_i (
		.Clk         (Clk),
		.rstN        (rstN),
		.cpu         (cpu),
		.cpuReadData (cpuReadData),
		.regs        (regs),
		.spanStart   (spanStart),
		.lineStart   (lineStart),
		.command     (command),
		.spanDone    (spanDone),
		.lineDone    (lineDone)
	);

	////////////////////////////////////////
	// drawing engines, side by side
	////////////////////////////////////////

	gfxSpanEngine gfxSpanEngine_i (
		.Clk       (Clk),
		.rstN      (rstN),
		.regs      (regs),
		.spanStart (spanStart),
		.command   (command),
		.pixelReq  (spanReq),
		.spanDone  (spanDone)
	);

	gfxLineEngine gfxLineEngine_i (
		.Clk       (Clk),
		.rstN      (rstN),
		.regs      (regs),
		.lineStart (lineStart),
		.pixelReq  (lineReq),
		.lineDone  (lineDone)
	);

	// sram cycles
	gfxFrameBufferPort gfxFrameBufferPort_i (
		.Clk     (Clk),
		.rstN    (rstN),
		.spanReq (spanReq),
		.lineReq (lineReq),
		.colour  (regs.colour),
		.fb      (fb)
	);

endmodule

// File: verification/gfxTbTasks.svh
////////////////////////////////////////
// cpu bus
////////////////////////////////////////

function automatic gfxPkg::cpuBus_s idleBus();
	gfxPkg::cpuBus_s bus;
	bus      = '0;
	bus.csN  = 1'b1;
	bus.asN  = 1'b1;  // no bus cycle
	bus.udsN = 1'b1;
	bus.ldsN = 1'b1;
	bus.rw   = 1'b1;
	return bus;
endfunction

// one cycle write, also tracked in the shadow registers
task automatic writeReg(gfxPkg::regOffset_e off, gfxPkg::cpuData_t data, logic upper,
	logic lower);
	gfxPkg::cpuBus_s bus;
	bus      = idleBus();
	bus.csN  = 1'b0;
	bus.asN  = 1'b0;
	bus.udsN = !upper;
	bus.ldsN = !lower;
	bus.rw   = 1'b0;
	bus.addr = {gfxPkg::REG_PAGE, off, 1'b0};
	bus.data = data;
	@(posedge Clk);
	cpu <= bus;
	@(posedge Clk);
	cpu <= idleBus();
	case (off)
		gfxPkg::X1: begin
			if (upper) shadow.x1[15:8] = data[15:8];
			if (lower) shadow.x1[7:0] = data[7:0];
		end
		gfxPkg::Y1: begin
			if (upper) shadow.y1[15:8] = data[15:8];
			if (lower) shadow.y1[7:0] = data[7:0];
		end
		gfxPkg::X2: begin
			if (upper) shadow.x2[15:8] = data[15:8];
			if (lower) shadow.x2[7:0] = data[7:0];
		end
		gfxPkg::Y2: begin
			if (upper) shadow.y2[15:8] = data[15:8];
			if (lower) shadow.y2[7:0] = data[7:0];
		end
		gfxPkg::COLOUR: if (lower) shadow.colour = data[7:0];  // pixel sits in the odd byte
		default: ;
	endcase
endtask

task automatic readReg(gfxPkg::regOffset_e off, output gfxPkg::cpuData_t data);
	gfxPkg::cpuBus_s bus;
	bus      = idleBus();
	bus.csN  = 1'b0;
	bus.asN  = 1'b0;
	bus.udsN = 1'b0;
	bus.ldsN = 1'b0;
	bus.addr = {gfxPkg::REG_PAGE, off, 1'b0};
	@(posedge Clk);
	cpu <= bus;
	@(negedge Clk);
	data = cpuReadData;  // mid cycle, settled
	@(posedge Clk);
	cpu <= idleBus();
endtask

task automatic setCoords(int x1, int y1, int x2, int y2);
	writeReg(gfxPkg::X1, gfxPkg::cpuData_t'(x1), 1'b1, 1'b1);
	writeReg(gfxPkg::Y1, gfxPkg::cpuData_t'(y1), 1'b1, 1'b1);
	writeReg(gfxPkg::X2, gfxPkg::cpuData_t'(x2), 1'b1, 1'b1);
	writeReg(gfxPkg::Y2, gfxPkg::cpuData_t'(y2), 1'b1, 1'b1);
endtask

task automatic issueCommand(gfxPkg::command_e cmd);
	writeReg(gfxPkg::COMMAND, cmd, 1'b1, 1'b1);
	repeat (2) @(posedge Clk);  // AS high so the command can dispatch
endtask

task automatic waitIdle();
	gfxPkg::cpuData_t st;
	st = '0;
	while (st[0] !== 1'b1)
		readReg(gfxPkg::COMMAND, st);
	repeat (2) @(posedge Clk);  // last sram cycle trails the done pulse
endtask

////////////////////////////////////////
// reference drawing
////////////////////////////////////////

// word {y, x/2}, even x in the upper byte
function automatic void plotRef(int x, int y, gfxPkg::colour_t c);
	int word;
	word = (y & 511) * 512 + ((x >> 1) & 511);
	model[32'(word * 2 + (x & 1))] = c;
endfunction

function automatic void refLine(gfxPkg::drawRegs_s r);
	int x;
	int y;
	int dx;
	int dy;
	int sx;
	int sy;
	int major;
	int minor;
	int d;
	int i;
	logic steep;
	dx = int'(r.x2) - int'(r.x1);
	dy = int'(r.y2) - int'(r.y1);
	sx = (dx < 0) ? -1 : 1;
	sy = (dy < 0) ? -1 : 1;
	dx = (dx < 0) ? -dx : dx;
	dy = (dy < 0) ? -dy : dy;
	if (dx == 0 && dy == 0)
		return;  // nothing to draw
	steep = dy > dx;
	major = steep ? dy : dx;
	minor = steep ? dx : dy;
	d     = 2 * minor - major;
	x     = r.x1;
	y     = r.y1;
	for (i = 0; i <= major; i++) begin
		plotRef(x, y, r.colour);
		if (d >= 0) begin
			if (steep) x += sx;
			else y += sy;
			d -= 2 * major;
		end
		if (steep) y += sy;
		else x += sx;
		d += 2 * minor;
	end
endfunction

function automatic void refDraw(gfxPkg::command_e cmd, gfxPkg::drawRegs_s r);
	int lo;
	int hi;
	int i;
	case (cmd)
		gfxPkg::CMD_PUTPIXEL: plotRef(r.x1, r.y1, r.colour);
		gfxPkg::CMD_HLINE: begin
			lo = (r.x1 < r.x2) ? r.x1 : r.x2;
			hi = (r.x1 < r.x2) ? r.x2 : r.x1;
			for (i = lo; i <= hi; i++) plotRef(i, r.y1, r.colour);
		end
		gfxPkg::CMD_VLINE: begin
			lo = (r.y1 < r.y2) ? r.y1 : r.y2;
			hi = (r.y1 < r.y2) ? r.y2 : r.y1;
			for (i = lo; i <= hi; i++) plotRef(r.x1, i, r.colour);  // column at x1
		end
		gfxPkg::CMD_ALINE: refLine(r);
		default: ;
	endcase
endfunction

////////////////////////////////////////
// checks
////////////////////////////////////////

task automatic checkStatus(string name, gfxPkg::cpuData_t expected, gfxPkg::cpuData_t actual);
	checks++;
	if (actual !== expected) begin
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

task automatic checkPixel(string name, gfxPkg::colour_t expected, gfxPkg::colour_t actual);
	checks++;
	if (actual !== expected) begin
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		errors++;
	end
endtask

function automatic gfxPkg::colour_t sramByte(int unsigned k);
	return sram.exists(k) ? sram[k] : 8'h00;  // unwritten reads as zero
endfunction

// every expected pixel, then anything written outside the set
task automatic compareFrame(string name);
	foreach (model[k])
		checkPixel($sformatf("%s x=%0d y=%0d", name, k % 1024, k / 1024), model[k], sramByte(k));
	foreach (sram[k]) begin
		if (!model.exists(k)) begin
			$display("ERROR: %s wrote pixel x=%0d y=%0d outside the expected set",
				name, k % 1024, k / 1024);
			errors++;
		end
	end
endtask

task automatic runDraw(string name, gfxPkg::command_e cmd);
	sram.delete();
	model.delete();
	issueCommand(cmd);
	waitIdle();
	refDraw(cmd, shadow);
	compareFrame(name);
endtask

// File: verification/gfxControllerTb.sv
`timescale 1ns/1ps

module gfxControllerTb;

	// hline 251..307, vline 70..90, 30 alines of at most 61 pixels, one more pixel, long line 901
	localparam int PIXEL_BUDGET   = 2 + 57 + 21 + 30 * 61 + 1 + 901;
	localparam int CMD_COUNT      = 36;
	localparam int TIMEOUT_CYCLES = 2 * (PIXEL_BUDGET + 50 * CMD_COUNT);

	logic               Clk;
	logic               rstN;
	gfxPkg::cpuBus_s    cpu;
	gfxPkg::cpuData_t   cpuReadData;
	gfxPkg::fbBus_s     fb;

	gfxPkg::colour_t    sram[int unsigned];   // byte addressed, what the DUT wrote
	gfxPkg::colour_t    model[int unsigned];  // what the reference drew
	gfxPkg::drawRegs_s  shadow;               // register contents as the CPU wrote them
	int                 errors = 0;
	int                 checks = 0;
	int                 cycles = 0;

	`include "gfxTbTasks.svh"

	gfxController gfxController_i (
		.Clk         (Clk),
		.rstN        (rstN),
		.cpu         (cpu),
		.cpuReadData (cpuReadData),
		.fb          (fb)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// sram write cycles, one lane per strobe
	always @(negedge Clk) begin
		if (fb.rwN === 1'b0) begin
			if (fb.udsN === 1'b0)
				sram[32'({fb.addr, 1'b0})] = fb.data[15:8];  // even byte
			if (fb.ldsN === 1'b0)
				sram[32'({fb.addr, 1'b1})] = fb.data[7:0];
		end
	end

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT never returned to idle", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		gfxPkg::cpuData_t st;
		int i;
		int x1;
		int y1;
		int a;
		int b;
		int dx;
		int dy;
		cpu    <= idleBus();
		rstN   <= 1'b0;
		shadow = '{x1: 16'sd0, y1: 16'sd0, x2: gfxPkg::X2_RESET, y2: gfxPkg::Y2_RESET,
			colour: gfxPkg::COLOUR_RESET};
		void'($urandom(32'h583f_fb99));
		repeat (10) @(posedge Clk);
		rstN <= 1'b1;

		// out of reset
		@(negedge Clk);
		if (fb.udsN !== 1'b1 || fb.ldsN !== 1'b1 || fb.rwN !== 1'b1) begin
			$display("ERROR: frame buffer strobes are active after reset");
			errors++;
		end
		readReg(gfxPkg::COMMAND, st);
		checkStatus("reset status", 16'h0001, st);

		// putpixel, colour through the low lane only
		writeReg(gfxPkg::COLOUR, 16'hAB37, 1'b0, 1'b1);
		setCoords(100, 20, 0, 0);
		runDraw("putpixel even x", gfxPkg::CMD_PUTPIXEL);
		writeReg(gfxPkg::COLOUR, 16'hEE00, 1'b1, 1'b0);  // upper lane only, colour stays
		setCoords(101, 20, 0, 0);
		runDraw("putpixel odd x", gfxPkg::CMD_PUTPIXEL);

		writeReg(gfxPkg::COLOUR, 16'h005A, 1'b1, 1'b1);
		setCoords(307, 33, 251, 33);  // reversed, both ends odd
		runDraw("hline", gfxPkg::CMD_HLINE);

		writeReg(gfxPkg::COLOUR, 16'h00C3, 1'b1, 1'b1);
		setCoords(64, 90, 64, 70);
		runDraw("vline", gfxPkg::CMD_VLINE);

		// octant from the low index bits: steep, negative x, negative y
		for (i = 0; i < 30; i++) begin
			x1 = 200 + int'($urandom % 400);
			y1 = 100 + int'($urandom % 300);
			a  = int'($urandom % 60);
			b  = int'($urandom % 60);
			dx = i[0] ? ((a < b) ? a : b) : ((a < b) ? b : a);
			dy = i[0] ? ((a < b) ? b : a) : ((a < b) ? a : b);
			if (i[1])
				dx = -dx;
			if (i[2])
				dy = -dy;
			if (i % 10 == 9) begin
				dx = 0;  // zero length
				dy = 0;
			end
			writeReg(gfxPkg::COLOUR, gfxPkg::cpuData_t'(i + 8'h41), 1'b1, 1'b1);
			setCoords(x1, y1, x1 + dx, y1 + dy);
			runDraw($sformatf("aline %0d", i), gfxPkg::CMD_ALINE);
		end

		// span pixel while the line engine still holds its last position
		writeReg(gfxPkg::COLOUR, 16'h0066, 1'b1, 1'b1);
		setCoords(3, 7, 0, 0);
		runDraw("putpixel after lines", gfxPkg::CMD_PUTPIXEL);

		// status while a long line draws
		writeReg(gfxPkg::COLOUR, 16'h0099, 1'b1, 1'b1);
		setCoords(10, 5, 910, 300);
		sram.delete();
		model.delete();
		issueCommand(gfxPkg::CMD_ALINE);
		readReg(gfxPkg::COMMAND, st);
		checkStatus("status while drawing", 16'h0000, st);
		waitIdle();
		readReg(gfxPkg::COMMAND, st);
		checkStatus("status after long line", 16'h0001, st);
		refDraw(gfxPkg::CMD_ALINE, shadow);
		compareFrame("long line");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+verification
rtl/gfxPkg.sv
rtl/gfxRegisterFile.sv
rtl/gfxSpanEngine.sv
rtl/gfxLineEngine.sv
rtl/gfxFrameBufferPort.sv
rtl/gfxController.sv
verification/gfxControllerTb.sv

// File: build.sh
#!/bin/sh
# compile and run the gfxController testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module gfxControllerTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/VgfxControllerTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1
